//--- hw/ctrl_decision.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_decision (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     cmd_load,
    input  wire key_ctrl_pkg::key_t cmd_word0,
    input  wire key_ctrl_pkg::key_t cmd_word2,
    input  wire key_ctrl_pkg::key_t cmd_word3,
    output key_ctrl_pkg::ctrl_t     ctrl
);

    import key_ctrl_pkg::*;

    key_t              word0;
    key_t              word2;
    key_t              word3;
    ctrl_t             ctrl_nx;
    ctrl_t             slot1;
    ctrl_t             slot2;
    logic [MODE_W-1:0] mode_hot;

    // Sign picks the table, digit the entry
    function automatic logic [GAIN_W-1:0] gain_code(key_t sign, key_t digit,
                                                    logic [GAIN_W-1:0] old);
        logic [GAIN_W-1:0] pos;
        logic [GAIN_W-1:0] neg;
        case (digit)
            KEY_0: begin
                pos = GAIN_P0;
                neg = GAIN_N0;
            end
            KEY_1: begin
                pos = GAIN_P1;
                neg = GAIN_N1;
            end
            KEY_2: begin
                pos = GAIN_P2;
                neg = GAIN_N2;
            end
            KEY_3: begin
                pos = GAIN_P3;
                neg = GAIN_N3;
            end
            default: begin
                pos = GAIN_P4;
                neg = GAIN_N4;
            end
        endcase
        if (sign == KEY_PLUS) begin
            return pos;
        end else if (sign == KEY_MINUS) begin
            return neg;
        end
        return old;
    endfunction

    always_comb begin
        case (word0)
            MODE_D:  mode_hot = 5'b00001;
            MODE_P:  mode_hot = 5'b00010;
            MODE_G:  mode_hot = 5'b00100;
            MODE_N:  mode_hot = 5'b01000;
            MODE_K:  mode_hot = 5'b10000;
            default: mode_hot = '0;
        endcase
    end

    always_comb begin
        ctrl_nx = ctrl;
        case (word0)
            CMD_HIGH: ctrl_nx[HIGH_LSB +: GAIN_W] = gain_code(word2, word3, ctrl[HIGH_LSB +: GAIN_W]);
            CMD_MID:  ctrl_nx[MID_LSB +: GAIN_W] = gain_code(word2, word3, ctrl[MID_LSB +: GAIN_W]);
            CMD_LOW:  ctrl_nx[LOW_LSB +: GAIN_W] = gain_code(word2, word3, ctrl[LOW_LSB +: GAIN_W]);
            CMD_TONE: begin
                ctrl_nx[TONE_LSB +: GAIN_W] = gain_code(word2, word3, ctrl[TONE_LSB +: GAIN_W]);
                ctrl_nx[MODE_LSB +: MODE_W] = '0;
            end
            CMD_CLEAR: ctrl_nx = '0;
            CMD_RECALL: begin
                if (word2 == KEY_1) begin
                    ctrl_nx = slot1;
                end else if (word2 == KEY_2) begin
                    ctrl_nx = slot2;
                end
            end
            default: begin
                if (mode_hot != '0) begin
                    ctrl_nx[MODE_LSB +: MODE_W] = mode_hot;
                    ctrl_nx[TONE_LSB +: GAIN_W] = '0; // Mode and tone exclude each other
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word0 <= '0;
            word2 <= '0;
            word3 <= '0;
            ctrl  <= '0;
            slot1 <= '0;
            slot2 <= '0;
        end else begin
            if (cmd_load) begin
                word0 <= cmd_word0;
                word2 <= cmd_word2;
                word3 <= cmd_word3;
            end
            ctrl <= ctrl_nx; // Held command re-applied each cycle
            if (word0 == CMD_SAVE && word2 == KEY_1) begin
                slot1 <= ctrl;
            end
            if (word0 == CMD_SAVE && word2 == KEY_2) begin
                slot2 <= ctrl;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/edit_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module edit_fsm (
    input  wire                                              clk,
    input  wire                                              rst_n,
    input  wire                                              stroke,
    input  wire key_ctrl_pkg::key_t                          code,
    output logic                                             wr_en,
    output key_ctrl_pkg::row_t                               wr_row,
    output key_ctrl_pkg::col_t                               wr_col,
    output key_ctrl_pkg::key_t                               wr_data,
    output logic                                             clear_all,
    output logic                                             scroll,
    output key_ctrl_pkg::row_t                               cap_row,
    input  wire key_ctrl_pkg::key_t [key_ctrl_pkg::COLS-1:0] row_chars,
    output logic                                             cmd_load,
    output key_ctrl_pkg::key_t                               cmd_word0,
    output key_ctrl_pkg::key_t                               cmd_word2,
    output key_ctrl_pkg::key_t                               cmd_word3
);

    import key_ctrl_pkg::*;

    typedef enum logic [2:0] {IDLE, LINE1, LINE2, LINE3, REC1, REC2, REC3, SHIFT} state_t;

    state_t state;
    state_t state_nx;
    col_t   cursor;
    col_t   cursor_nx;
    logic   in_line;
    logic   back_key;

    function automatic row_t row_of(state_t s);
        case (s)
            LINE2, REC2:        return 2'd1;
            LINE3, REC3, SHIFT: return 2'd2;
            default:            return 2'd0;
        endcase
    endfunction

    assign in_line  = (state == LINE1) || (state == LINE2) || (state == LINE3);
    assign back_key = (code == KEY_BACK);

    always_comb begin
        state_nx  = state;
        cursor_nx = cursor;
        case (state)
            IDLE: begin
                cursor_nx = '0;
                if (stroke && code == KEY_START) begin
                    state_nx = LINE1;
                end
            end
            LINE1, LINE2, LINE3: begin
                if (stroke) begin
                    if (code == KEY_ENTER) begin
                        cursor_nx = '0;
                        case (state)
                            LINE1:   state_nx = LINE2;
                            LINE2:   state_nx = LINE3;
                            default: state_nx = SHIFT; // Full screen, scroll up
                        endcase
                    end else if (code == KEY_ESC) begin
                        state_nx = IDLE;
                    end else begin
                        if (back_key) begin
                            cursor_nx = (cursor != '0) ? cursor - 3'd1 : '0;
                        end else begin
                            cursor_nx = (cursor >= COLS) ? col_t'(COLS) : cursor + 3'd1;
                        end
                        case (state)
                            LINE1:   state_nx = REC1;
                            LINE2:   state_nx = REC2;
                            default: state_nx = REC3;
                        endcase
                    end
                end
            end
            REC1:    state_nx = LINE1;
            REC2:    state_nx = LINE2;
            REC3:    state_nx = LINE3;
            SHIFT:   state_nx = LINE3;
            default: state_nx = IDLE;
        endcase
    end

    // Buffer strobes line up with the state they belong to
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            cursor    <= '0;
            wr_en     <= 1'b0;
            clear_all <= 1'b0;
            scroll    <= 1'b0;
        end else begin
            state     <= state_nx;
            cursor    <= cursor_nx;
            wr_en     <= (state_nx == REC1) || (state_nx == REC2) || (state_nx == REC3);
            clear_all <= (state_nx == IDLE);
            scroll    <= (state_nx == SHIFT);
        end
    end

    always_ff @(posedge clk) begin
        wr_row  <= row_of(state_nx);
        wr_col  <= back_key ? cursor_nx : cursor_nx - 3'd1;
        wr_data <= back_key ? '0 : code;
    end

    // Command taken from the current row, before any scroll
    assign cap_row   = row_of(state);
    assign cmd_load  = stroke && in_line && (code == KEY_ENTER);
    assign cmd_word0 = row_chars[0];
    assign cmd_word2 = row_chars[2];
    assign cmd_word3 = row_chars[3];

endmodule

`default_nettype wire

//--- hw/key_ctrl_pkg.sv
`default_nettype none

package key_ctrl_pkg;

    localparam int KEY_W  = 8;
    localparam int ROWS   = 3;
    localparam int COLS   = 5;
    localparam int CTRL_W = 21;
    localparam int GAIN_W = 4;
    localparam int MODE_W = 5;

    typedef logic [KEY_W-1:0]  key_t;
    typedef logic [1:0]        row_t;
    typedef logic [2:0]        col_t;
    typedef logic [CTRL_W-1:0] ctrl_t;

    // Editing keys
    localparam key_t KEY_START = 8'h2C;
    localparam key_t KEY_ENTER = 8'h5A;
    localparam key_t KEY_BACK  = 8'h66;
    localparam key_t KEY_ESC   = 8'h24;
    localparam key_t KEY_PLUS  = 8'h55;
    localparam key_t KEY_MINUS = 8'h4E;
    localparam key_t KEY_0     = 8'h45;
    localparam key_t KEY_1     = 8'h16;
    localparam key_t KEY_2     = 8'h1E;
    localparam key_t KEY_3     = 8'h26;
    localparam key_t KEY_4     = 8'h25;

    // Command letters, first word of a line
    localparam key_t CMD_HIGH   = 8'h33;
    localparam key_t CMD_MID    = 8'h1B;
    localparam key_t CMD_LOW    = 8'h43;
    localparam key_t CMD_TONE   = 8'h2C; // Same code as the start key
    localparam key_t CMD_CLEAR  = 8'h15;
    localparam key_t CMD_RECALL = 8'h1C;
    localparam key_t CMD_SAVE   = 8'h2D;
    localparam key_t MODE_G     = 8'h34;
    localparam key_t MODE_N     = 8'h31;
    localparam key_t MODE_K     = 8'h42;
    localparam key_t MODE_D     = 8'h23;
    localparam key_t MODE_P     = 8'h4D;

    // Control word layout
    localparam int LOW_LSB  = 0;
    localparam int MID_LSB  = 4;
    localparam int HIGH_LSB = 8;
    localparam int MODE_LSB = 12;
    localparam int TONE_LSB = 17;

    localparam logic [GAIN_W-1:0] GAIN_P0 = 4'b0000;
    localparam logic [GAIN_W-1:0] GAIN_P1 = 4'b0011;
    localparam logic [GAIN_W-1:0] GAIN_P2 = 4'b1011;
    localparam logic [GAIN_W-1:0] GAIN_P3 = 4'b0111;
    localparam logic [GAIN_W-1:0] GAIN_P4 = 4'b1111;
    localparam logic [GAIN_W-1:0] GAIN_N0 = 4'b0000;
    localparam logic [GAIN_W-1:0] GAIN_N1 = 4'b1101;
    localparam logic [GAIN_W-1:0] GAIN_N2 = 4'b0101;
    localparam logic [GAIN_W-1:0] GAIN_N3 = 4'b1001;
    localparam logic [GAIN_W-1:0] GAIN_N4 = 4'b0001;

endpackage

`default_nettype wire

//--- hw/key_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module key_ctrl_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire key_ctrl_pkg::key_t  key,
    input  wire                      valid,
    input  wire key_ctrl_pkg::row_t  char_row,
    input  wire key_ctrl_pkg::col_t  char_col,
    output wire key_ctrl_pkg::key_t  char_code,
    output wire key_ctrl_pkg::ctrl_t ctrl
);

    import key_ctrl_pkg::*;

    wire                   stroke;
    wire key_t             code;
    wire                   wr_en;
    wire row_t             wr_row;
    wire col_t             wr_col;
    wire key_t             wr_data;
    wire                   clear_all;
    wire                   scroll;
    wire row_t             cap_row;
    wire key_t [COLS-1:0]  row_chars;
    wire                   cmd_load;
    wire key_t             cmd_word0;
    wire key_t             cmd_word2;
    wire key_t             cmd_word3;

    key_strobe key_strobe_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .key    (key),
        .valid  (valid),
        .stroke (stroke),
        .code   (code)
    );

    edit_fsm edit_fsm_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .stroke    (stroke),
        .code      (code),
        .wr_en     (wr_en),
        .wr_row    (wr_row),
        .wr_col    (wr_col),
        .wr_data   (wr_data),
        .clear_all (clear_all),
        .scroll    (scroll),
        .cap_row   (cap_row),
        .row_chars (row_chars),
        .cmd_load  (cmd_load),
        .cmd_word0 (cmd_word0),
        .cmd_word2 (cmd_word2),
        .cmd_word3 (cmd_word3)
    );

    line_buffer line_buffer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_row    (wr_row),
        .wr_col    (wr_col),
        .wr_data   (wr_data),
        .clear_all (clear_all),
        .scroll    (scroll),
        .cap_row   (cap_row),
        .row_chars (row_chars),
        .char_row  (char_row),
        .char_col  (char_col),
        .char_code (char_code)
    );

    ctrl_decision ctrl_decision_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_load  (cmd_load),
        .cmd_word0 (cmd_word0),
        .cmd_word2 (cmd_word2),
        .cmd_word3 (cmd_word3),
        .ctrl      (ctrl)
    );

endmodule

`default_nettype wire

//--- hw/key_strobe.sv
`timescale 1ns/1ps
`default_nettype none

module key_strobe (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire key_ctrl_pkg::key_t key,
    input  wire                     valid,
    output logic                    stroke,
    output key_ctrl_pkg::key_t      code
);

    logic valid_s; // Sampled valid
    logic valid_d;
    logic fall;

    assign fall = valid_d & ~valid_s;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s <= 1'b0;
            valid_d <= 1'b0;
            stroke  <= 1'b0;
        end else begin
            valid_s <= valid;
            valid_d <= valid_s;
            stroke  <= fall;
        end
    end

    // Key still stable here, held until the next stroke
    always_ff @(posedge clk) begin
        if (fall) begin
            code <= key;
        end
    end

endmodule

`default_nettype wire

//--- hw/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
    input  wire                                              clk,
    input  wire                                              rst_n,
    input  wire                                              wr_en,
    input  wire key_ctrl_pkg::row_t                          wr_row,
    input  wire key_ctrl_pkg::col_t                          wr_col,
    input  wire key_ctrl_pkg::key_t                          wr_data,
    input  wire                                              clear_all,
    input  wire                                              scroll,
    input  wire key_ctrl_pkg::row_t                          cap_row,
    output key_ctrl_pkg::key_t [key_ctrl_pkg::COLS-1:0]      row_chars,
    input  wire key_ctrl_pkg::row_t                          char_row,
    input  wire key_ctrl_pkg::col_t                          char_col,
    output key_ctrl_pkg::key_t                               char_code
);

    import key_ctrl_pkg::*;

    key_t [COLS-1:0] rows [ROWS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < ROWS; r++) begin
                rows[r] <= '0;
            end
        end else if (clear_all) begin
            for (int r = 0; r < ROWS; r++) begin
                rows[r] <= '0;
            end
        end else if (scroll) begin
            for (int r = 0; r < ROWS - 1; r++) begin
                rows[r] <= rows[r+1];
            end
            rows[ROWS-1] <= '0;
        end else if (wr_en && wr_row < ROWS && wr_col < COLS) begin
            rows[wr_row][wr_col] <= wr_data;
        end
    end

    assign row_chars = (cap_row < ROWS) ? rows[cap_row] : '0;

    // Outside the text area reads as blank
    assign char_code = (char_row < ROWS && char_col < COLS) ? rows[char_row][char_col] : '0;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_key_ctrl -o sim_key_ctrl
./obj_dir/sim_key_ctrl | tee sim.log

if grep -q "^>>> PASS$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- test/key_input.txt
# K <scan code hex> presses one key. C <row> <col> <char hex> reads the buffer.
# T <name> <ctrl hex> checks the control word after the last command.
# Keys before the start key are ignored
K 1c K 32
C 0 0 00 C 0 1 00
# Start, then six keys on a five-column row
K 2c
K 1c K 32 K 21 K 23 K 2b K 34
C 0 0 1c C 0 1 32 C 0 3 23 C 0 4 34 C 0 5 00 C 3 0 00
# Backspace frees column 4, escape clears everything
K 66 C 0 4 00 C 0 3 23
K 4d C 0 4 4d
K 24 C 0 0 00 C 0 4 00
# Each enter moves down a row, enter on the last row scrolls up
K 2c
K 3b K 5a
K 32 K 5a
C 0 0 3b C 1 0 32
K 21 K 5a
C 0 0 32 C 1 0 21 C 2 0 00
K 3b C 2 0 3b C 1 0 21
K 24
T after_edit 000000
# Commands: word 0, space, sign or slot, digit, enter
K 2c
K 33 K 29 K 55 K 26 K 5a T high_p3 000700
K 33 K 29 K 4e K 16 K 5a T high_n1 000d00
K 43 K 29 K 55 K 1e K 5a T low_p2 000d0b
K 1b K 29 K 4e K 25 K 5a T mid_n4 000d1b
K 2c K 29 K 55 K 16 K 5a T tone_p1 060d1b
# Mode letters
K 42 K 5a T mode_k 010d1b
K 23 K 5a T mode_d 001d1b
K 33 K 29 K 29 K 16 K 5a T bad_sign 001d1b
# Style slots
K 2d K 29 K 16 K 5a T save1 001d1b
K 15 K 5a T clear 000000
K 33 K 29 K 55 K 25 K 5a T high_p4 000f00
K 2d K 29 K 1e K 5a T save2 000f00
K 43 K 29 K 4e K 3b K 5a T low_unknown 000f01
K 1c K 29 K 16 K 5a T recall1 001d1b
K 1c K 29 K 1e K 5a T recall2 000f00

//--- test/tb_key_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_key_ctrl;

    import key_ctrl_pkg::*;

    logic  clk;
    logic  rst_n;
    key_t  key;
    logic  valid;
    row_t  char_row;
    col_t  char_col;
    key_t  char_code;
    ctrl_t ctrl;

    // Records parsed from the data file
    logic [7:0]      rec_kind [$];
    logic [31:0]     rec_a [$];
    logic [31:0]     rec_b [$];
    logic [31:0]     rec_c [$];
    logic [8*24-1:0] rec_name [$];

    int errors;
    int cycles;
    int limit;

    key_ctrl_top key_ctrl_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .key       (key),
        .valid     (valid),
        .char_row  (char_row),
        .char_col  (char_col),
        .char_code (char_code),
        .ctrl      (ctrl)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            errors = errors + 1;
            $display("Run timed out after %0d cycles", cycles);
            $display("Checks done, errors: %0d", errors);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors = errors + 1;
        end
    endtask

    task automatic load_records;
        int               fd;
        int               n;
        logic [8*24-1:0]  tok;
        logic [8*128-1:0] rest;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        logic [8*24-1:0]  name;
        fd = $fopen("test/key_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the data file test/key_input.txt");
            errors = errors + 1;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            a    = '0;
            b    = '0;
            c    = '0;
            name = '0;
            if (tok == "#") begin
                n = ($fgets(rest, fd) > 0) ? 1 : 0; // Rest of a comment line
            end else if (tok == "K") begin
                n = $fscanf(fd, "%h", a);
                rec_kind.push_back("K");
            end else if (tok == "C") begin
                n = $fscanf(fd, "%d %d %h", a, b, c) - 2;
                rec_kind.push_back("C");
            end else if (tok == "T") begin
                n = $fscanf(fd, "%s %h", name, c) - 1;
                rec_kind.push_back("T");
            end else begin
                n = 1;
                $display("Data file holds an unknown record type %0s", tok);
                errors = errors + 1;
            end
            if (n != 1) begin
                $display("Data file record %0s is missing a field", tok);
                errors = errors + 1;
            end
            if (tok == "K" || tok == "C" || tok == "T") begin
                rec_a.push_back(a);
                rec_b.push_back(b);
                rec_c.push_back(c);
                rec_name.push_back(name);
            end
        end
        $fclose(fd);
    endtask

    // One key press, then the idle gap the keyboard guarantees
    task automatic press_key(input key_t code);
        key   = code;
        valid = 1'b1;
        repeat (2) @(negedge clk);
        valid = 1'b0;
        repeat (6) @(negedge clk);
    endtask

    task automatic check_char(input int r, input int c, input logic [31:0] expected);
        char_row = row_t'(r);
        char_col = col_t'(c);
        @(negedge clk);
        check_value($sformatf("char_r%0d_c%0d", r, c), expected, {24'b0, char_code});
    endtask

    task automatic check_ctrl(input logic [8*24-1:0] name, input logic [31:0] expected);
        repeat (6) @(negedge clk);
        check_value($sformatf("%0s", name), expected, {11'b0, ctrl});
    endtask

    initial begin
        errors   = 0;
        cycles   = 0;
        rst_n    = 1'b0;
        key      = '0;
        valid    = 1'b0;
        char_row = '0;
        char_col = '0;
        load_records();
        limit = 40 * rec_kind.size() + 100;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        foreach (rec_kind[i]) begin
            case (rec_kind[i])
                "K":     press_key(key_t'(rec_a[i]));
                "C":     check_char(int'(rec_a[i]), int'(rec_b[i]), rec_c[i]);
                "T":     check_ctrl(rec_name[i], rec_c[i]);
                default: ;
            endcase
        end
        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/key_ctrl_pkg.sv
hw/key_strobe.sv
hw/edit_fsm.sv
hw/line_buffer.sv
hw/ctrl_decision.sv
hw/key_ctrl_top.sv
test/tb_key_ctrl.sv
